// File: sim.f
hw/clk_cfg_pkg.sv
hw/drp_pkg.sv
hw/serdes_clk_drp.sv
hw/pll_reconfig_regs.sv
hw/pll_clk_gen.sv
hw/serdes_clk_top.sv
test/serdes_clk_tb.sv

// File: Makefile
# Verilator build and run of the serdes clock block testbench

SRCS := $(shell cat sim.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vserdes_clk_tb: sim.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module serdes_clk_tb -f sim.f

# pass only when the pass message is printed
run: obj_dir/Vserdes_clk_tb
	@out=$$(./obj_dir/Vserdes_clk_tb 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir

// File: test/serdes_clk_tb.sv
// testbench for the serdes clock block
// bus tasks with ready timeout, lock waits,
// div_clk and loaden measurement, directed tests

`default_nettype none

module serdes_clk_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LOCK_CYCLES  = 16;
  localparam int ADDR_WIDTH   = 12;
  // wait limits in clock cycles
  localparam int BUS_TIMEOUT  = 100;
  localparam int LOCK_TIMEOUT = 200;
  // longest counter level is 255 and longest period 510
  localparam int MEAS_TIMEOUT = 600;

  // register map on the outside address
  localparam logic [ADDR_WIDTH-1:0] A_STATUS = 12'h000;
  localparam logic [ADDR_WIDTH-1:0] A_CTRL   = 12'h001;
  localparam logic [ADDR_WIDTH-1:0] A_C0     = 12'h002;
  localparam logic [ADDR_WIDTH-1:0] A_C1     = 12'h003;
  localparam logic [ADDR_WIDTH-1:0] A_UNMAP  = 12'h004;

  // one clock feeds clk_in and up_clk
  logic                  clk = 1'b0;
  logic                  up_rstn;
  logic                  up_drp_sel;
  logic                  up_drp_wr;
  logic [ADDR_WIDTH-1:0] up_drp_addr;
  logic [31:0]           up_drp_wdata;
  logic [31:0]           up_drp_rdata;
  logic                  up_drp_ready;
  logic                  up_drp_locked;
  logic                  div_clk;
  logic                  loaden;
  logic [7:0]            phase;

  // counter settings of the last reconfiguration
  logic [7:0]            c0_hi;
  logic [7:0]            c0_lo;
  logic [7:0]            c1_hi;
  logic [7:0]            c1_lo;
  // cycles seen with up_drp_locked low
  int                    unlocked_cycles = 0;

  serdes_clk_top #(
    .LOCK_CYCLES (LOCK_CYCLES),
    .ADDR_WIDTH  (ADDR_WIDTH)
  ) DUT (
    .clk_in        (clk),
    .div_clk       (div_clk),
    .loaden        (loaden),
    .phase         (phase),
    .up_clk        (clk),
    .up_rstn       (up_rstn),
    .up_drp_sel    (up_drp_sel),
    .up_drp_wr     (up_drp_wr),
    .up_drp_addr   (up_drp_addr),
    .up_drp_wdata  (up_drp_wdata),
    .up_drp_rdata  (up_drp_rdata),
    .up_drp_ready  (up_drp_ready),
    .up_drp_locked (up_drp_locked)
  );

  always #50 clk = ~clk;

  // lock monitor sampled mid cycle
  always @(negedge clk) begin
    if (!up_drp_locked) begin
      unlocked_cycles <= unlocked_cycles + 1;
    end
  end

  // ******************************
  // checking helpers
  // ******************************

  task automatic stop_run;
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("ERROR %s", what);
      stop_run();
    end
  endtask

  // a zero field counts as one cycle
  function automatic int zero_as_one(input logic [7:0] v);
    return (v == 8'd0) ? 1 : int'(v);
  endfunction

  // ******************************
  // bus tasks
  // ******************************

  // entered and left 10 ns after a rising edge
  // latency counts cycles from sel to ready
  task automatic bus_transfer(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int latency);
    up_drp_sel   = 1'b1;
    up_drp_wr    = wr;
    up_drp_addr  = addr;
    up_drp_wdata = wdata;
    @(posedge clk);
    #10;
    // one strobe only since the bridge holds the request
    up_drp_sel   = 1'b0;
    up_drp_wr    = 1'b0;
    up_drp_addr  = '0;
    up_drp_wdata = '0;
    latency = 1;
    while (!up_drp_ready && latency <= BUS_TIMEOUT) begin
      @(posedge clk);
      #10;
      latency++;
    end
    check_true(up_drp_ready, "bus request got no ready within the timeout");
    rdata = up_drp_rdata;
    @(posedge clk);
    #10;
    // ready lasts one cycle
    check_eq("up_drp_ready", 32'(up_drp_ready), 32'h0);
  endtask

  task automatic drp_write(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] wdata,
                           output int latency);
    logic [31:0] unused_rdata;
    bus_transfer(1'b1, addr, wdata, unused_rdata, latency);
  endtask

  task automatic drp_read(input logic [ADDR_WIDTH-1:0] addr, output logic [31:0] rdata,
                          output int latency);
    bus_transfer(1'b0, addr, 32'h0, rdata, latency);
  endtask

  task automatic wait_locked(input logic level);
    int n;
    n = 0;
    while (up_drp_locked !== level && n < LOCK_TIMEOUT) begin
      @(posedge clk);
      #10;
      n++;
    end
    check_true(up_drp_locked === level, "up_drp_locked did not reach its level in time");
  endtask

  // ******************************
  // clock measurement
  // ******************************

  // outputs sampled at the falling edge where they are stable
  task automatic measure_div_clk(output int hi_cycles, output int lo_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (div_clk !== 1'b0 && n < MEAS_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    while (div_clk !== 1'b1 && n < MEAS_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    check_true(div_clk === 1'b1, "div_clk showed no rising edge");
    hi_cycles = 0;
    while (div_clk === 1'b1 && hi_cycles < MEAS_TIMEOUT) begin
      hi_cycles++;
      @(negedge clk);
    end
    lo_cycles = 0;
    while (div_clk === 1'b0 && lo_cycles < MEAS_TIMEOUT) begin
      lo_cycles++;
      @(negedge clk);
    end
    @(posedge clk);
    #10;
  endtask

  // phase is checked on every cycle of one period
  task automatic measure_loaden(output int period);
    int n;
    n = 0;
    @(negedge clk);
    while (loaden !== 1'b1 && n < MEAS_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    check_true(loaden === 1'b1, "no loaden pulse seen");
    check_eq("phase", 32'(phase), 32'h0);
    @(negedge clk);
    period = 1;
    while (loaden !== 1'b1 && period < MEAS_TIMEOUT) begin
      check_eq("phase", 32'(phase), 32'(period));
      @(negedge clk);
      period++;
    end
    check_eq("phase", 32'(phase), 32'h0);
    @(posedge clk);
    #10;
  endtask

  task automatic check_clocks(input int exp_hi, input int exp_lo, input int exp_period);
    int hi_cycles;
    int lo_cycles;
    int period;
    measure_div_clk(hi_cycles, lo_cycles);
    check_eq("div_clk high cycles", 32'(hi_cycles), 32'(exp_hi));
    check_eq("div_clk low cycles", 32'(lo_cycles), 32'(exp_lo));
    measure_loaden(period);
    check_eq("loaden period", 32'(period), 32'(exp_period));
  endtask

  // ******************************
  // directed tests
  // ******************************

  task automatic test_reset_lock;
    logic [31:0] rdata;
    int          latency;
    check_eq("up_drp_ready", 32'(up_drp_ready), 32'h0);
    check_eq("up_drp_locked", 32'(up_drp_locked), 32'h0);
    wait_locked(1'b1);
    drp_read(A_STATUS, rdata, latency);
    check_eq("status", rdata, 32'h1);
  endtask

  task automatic test_default_clocks;
    // reset shape gives div_clk 2/2 and serdes factor 8
    check_clocks(2, 2, 8);
  endtask

  task automatic test_read_back;
    logic [7:0]  v [4];
    logic [31:0] rdata;
    int          latency;
    foreach (v[i]) begin
      v[i] = 8'(1 + ($urandom % 15));
    end
    drp_write(A_C0, {16'h0, v[0], v[1]}, latency);
    check_eq("write latency", 32'(latency), 32'd2);
    drp_write(A_C1, {16'h0, v[2], v[3]}, latency);
    check_eq("write latency", 32'(latency), 32'd2);
    drp_read(A_C0, rdata, latency);
    check_eq("c0 read back", rdata, {16'h0, v[0], v[1]});
    check_eq("read latency", 32'(latency), 32'd2);
    drp_read(A_C1, rdata, latency);
    check_eq("c1 read back", rdata, {16'h0, v[2], v[3]});
    drp_read(A_UNMAP, rdata, latency);
    check_eq("unmapped read", rdata, 32'h0);
    check_eq("read latency", 32'(latency), 32'd2);
  endtask

  task automatic test_reconfig;
    logic [31:0] rdata;
    int          latency;
    int          unlocked_before;
    // low width of zero counts as one
    c0_hi = 8'(1 + ($urandom % 15));
    c0_lo = 8'h00;
    c1_hi = 8'(1 + ($urandom % 15));
    c1_lo = 8'(1 + ($urandom % 15));
    drp_write(A_C0, {16'h0, c0_hi, c0_lo}, latency);
    drp_write(A_C1, {16'h0, c1_hi, c1_lo}, latency);
    unlocked_before = unlocked_cycles;
    drp_write(A_CTRL, 32'h1, latency);
    check_eq("start write latency", 32'(latency), 32'd2);
    // stalls until the generator has locked again
    drp_read(A_STATUS, rdata, latency);
    check_true(latency > 2, "status read after start was not stalled");
    check_eq("status", rdata, 32'h1);
    check_true(unlocked_cycles > unlocked_before, "up_drp_locked never dropped on start");
    check_eq("up_drp_locked", 32'(up_drp_locked), 32'h1);
    check_clocks(zero_as_one(c0_hi), zero_as_one(c0_lo),
                 zero_as_one(c1_hi) + zero_as_one(c1_lo));
  endtask

  task automatic test_restart;
    int latency;
    drp_write(A_CTRL, 32'h2, latency);
    wait_locked(1'b0);
    wait_locked(1'b1);
    check_clocks(zero_as_one(c0_hi), zero_as_one(c0_lo),
                 zero_as_one(c1_hi) + zero_as_one(c1_lo));
  endtask

  initial begin
    void'($urandom(91));
    up_rstn      = 1'b0;
    up_drp_sel   = 1'b0;
    up_drp_wr    = 1'b0;
    up_drp_addr  = '0;
    up_drp_wdata = '0;
    repeat (3) @(posedge clk);
    #10;
    up_rstn = 1'b1;
    test_reset_lock();
    test_default_clocks();
    test_read_back();
    test_reconfig();
    test_restart();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/serdes_clk_top.sv
// serdes clock block top level
// request bridge, pll register file and clock generator

`default_nettype none

module serdes_clk_top #(
  parameter int LOCK_CYCLES = 16,
  parameter int ADDR_WIDTH  = 12
) (

  // reference clock and generated clocks
  input  wire                   clk_in,
  output logic                  div_clk,
  output logic                  loaden,
  output logic [7:0]            phase,

  // reconfiguration port
  input  wire                   up_clk,
  input  wire                   up_rstn,
  input  wire                   up_drp_sel,
  input  wire                   up_drp_wr,
  input  wire [ADDR_WIDTH-1:0]  up_drp_addr,
  input  wire [31:0]            up_drp_wdata,
  output logic [31:0]           up_drp_rdata,
  output logic                  up_drp_ready,
  output logic                  up_drp_locked
);

  // bridge and register file
  drp_pkg::drp_req_t     req;
  drp_pkg::drp_rsp_t     rsp;

  // register file and generator
  clk_cfg_pkg::pll_cfg_t cfg;
  logic                  gen_restart;

  // raw lock flag, clk_in domain
  logic                  locked;

  serdes_clk_drp #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_drp (
    .up_clk        (up_clk),
    .up_rstn       (up_rstn),
    .up_drp_sel    (up_drp_sel),
    .up_drp_wr     (up_drp_wr),
    .up_drp_addr   (up_drp_addr),
    .up_drp_wdata  (up_drp_wdata),
    .up_drp_rdata  (up_drp_rdata),
    .up_drp_ready  (up_drp_ready),
    .up_drp_locked (up_drp_locked),
    .req           (req),
    .rsp           (rsp),
    .locked        (locked)
  );

  // register file sees lock after the synchronizer
  pll_reconfig_regs #(
    .LOCK_CYCLES (LOCK_CYCLES)
  ) i_regs (
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .req         (req),
    .rsp         (rsp),
    .locked      (up_drp_locked),
    .cfg         (cfg),
    .gen_restart (gen_restart)
  );

  pll_clk_gen #(
    .LOCK_CYCLES (LOCK_CYCLES)
  ) i_gen (
    .clk_in      (clk_in),
    .up_rstn     (up_rstn),
    .cfg         (cfg),
    .gen_restart (gen_restart),
    .div_clk     (div_clk),
    .loaden      (loaden),
    .phase       (phase),
    .locked      (locked)
  );

endmodule

`default_nettype wire

// File: hw/pll_clk_gen.sv
// cycle based pll clock generator
// lock counter for settling, div_clk shaping from c0,
// loaden pulse and phase position from c1

`default_nettype none

module pll_clk_gen #(
  parameter int LOCK_CYCLES = 16
) (
  input  wire                          clk_in,
  input  wire                          up_rstn,

  // configuration and reload pulse from the register file
  input  wire clk_cfg_pkg::pll_cfg_t   cfg,
  input  wire                          gen_restart,

  // generated outputs
  output logic                         div_clk,
  output logic                         loaden,
  output logic [7:0]                   phase,
  output logic                         locked
);

  localparam int LCK_W = $clog2(LOCK_CYCLES + 1);

  logic [LCK_W-1:0] lock_cnt;
  logic [7:0]       div_cnt;
  logic [8:0]       ld_cnt;

  // effective counter limits, zero fields count as one
  logic [7:0]       c0_hi;
  logic [7:0]       c0_lo;
  logic [7:0]       div_lim;
  logic [8:0]       ld_lim;

  assign c0_hi = clk_cfg_pkg::cnt_eff(cfg.c0.hi);
  assign c0_lo = clk_cfg_pkg::cnt_eff(cfg.c0.lo);

  // last count of the current div_clk level
  assign div_lim = (div_clk ? c0_hi : c0_lo) - 8'd1;

  // last phase of the loaden period
  assign ld_lim = clk_cfg_pkg::cnt_period(cfg.c1) - 9'd1;

  // phase wraps only for periods above 256
  assign phase = ld_cnt[7:0];

  // ******************************
  // lock and output counters
  // ******************************

  always_ff @(posedge clk_in) begin
    if (!up_rstn || gen_restart) begin
      // reset behaves like a restart, lock count starts over
      lock_cnt <= '0;
      locked   <= 1'b0;
      div_cnt  <= '0;
      div_clk  <= 1'b0;
      ld_cnt   <= '0;
      loaden   <= 1'b0;
    end else if (!locked) begin
      // settling, outputs stay low
      if (lock_cnt == LCK_W'(LOCK_CYCLES - 1)) begin
        // both outputs start together with lock
        locked  <= 1'b1;
        div_clk <= 1'b1;
        loaden  <= 1'b1;
      end else begin
        lock_cnt <= lock_cnt + 1'b1;
      end
    end else begin
      // div_clk, toggle after hi or lo cycles
      if (div_cnt == div_lim) begin
        div_clk <= ~div_clk;
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end

      // loaden, one pulse per period at phase zero
      if (ld_cnt == ld_lim) begin
        ld_cnt <= '0;
        loaden <= 1'b1;
      end else begin
        ld_cnt <= ld_cnt + 1'b1;
        loaden <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/pll_reconfig_regs.sv
// pll reconfiguration register file
// shadow and active counter settings, control decode,
// reconfiguration sequencer with lock watchdog, waitrequest

`default_nettype none

module pll_reconfig_regs #(
  parameter int LOCK_CYCLES = 16
) (
  input  wire                       up_clk,
  input  wire                       up_rstn,

  // held request from the bridge and its response
  input  wire drp_pkg::drp_req_t    req,
  output drp_pkg::drp_rsp_t         rsp,

  // lock flag, already in up_clk
  input  wire                       locked,

  // generator control
  output clk_cfg_pkg::pll_cfg_t     cfg,
  output logic                      gen_restart
);

  // watchdog limit, lock normally returns well before this
  localparam int WD_MAX = 2 * LOCK_CYCLES;
  localparam int WD_W   = $clog2(WD_MAX + 1);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RESTART,
    SEQ_WAIT_LOCK
  } seq_state_t;

  seq_state_t            state;
  logic [WD_W-1:0]       wd_cnt;
  logic                  lock_dropped;
  clk_cfg_pkg::cnt_cfg_t shadow_c0;
  clk_cfg_pkg::cnt_cfg_t shadow_c1;
  drp_pkg::drp_word_t    wr_word;
  drp_pkg::drp_word_t    rd_word;
  logic                  busy;
  logic                  wr_acc;
  logic                  ctl_wr;
  logic                  wd_expired;

  assign busy       = (state != SEQ_IDLE);
  assign wr_word    = req.wdata;
  // writes land on the same edge as busy is seen low
  assign wr_acc     = req.wr & ~busy;
  assign ctl_wr     = wr_acc & (req.addr == drp_pkg::ADDR_CTRL);
  assign wd_expired = (wd_cnt == WD_W'(WD_MAX));

  // one cycle pulse, the generator reloads on it
  assign gen_restart = (state == SEQ_RESTART);

  // ******************************
  // shadow counter registers
  // ******************************

  // only shadow copies change here, cfg moves on start
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      shadow_c0 <= clk_cfg_pkg::CFG_RESET.c0;
      shadow_c1 <= clk_cfg_pkg::CFG_RESET.c1;
    end else if (wr_acc) begin
      if (req.addr == drp_pkg::ADDR_C0) begin
        shadow_c0 <= wr_word.cnt.cfg;
      end
      if (req.addr == drp_pkg::ADDR_C1) begin
        shadow_c1 <= wr_word.cnt.cfg;
      end
    end
  end

  // ******************************
  // reconfiguration sequencer
  // ******************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      state        <= SEQ_IDLE;
      cfg          <= clk_cfg_pkg::CFG_RESET;
      wd_cnt       <= '0;
      lock_dropped <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (ctl_wr && (wr_word.ctl.start || wr_word.ctl.restart)) begin
            // start loads new settings, restart keeps them
            if (wr_word.ctl.start) begin
              cfg <= '{c0: shadow_c0, c1: shadow_c1};
            end
            state <= SEQ_RESTART;
          end
        end
        SEQ_RESTART: begin
          wd_cnt       <= '0;
          lock_dropped <= 1'b0;
          state        <= SEQ_WAIT_LOCK;
        end
        SEQ_WAIT_LOCK: begin
          // synchronized lock lags, so wait for it to fall first
          if (!locked) begin
            lock_dropped <= 1'b1;
          end
          wd_cnt <= wd_cnt + 1'b1;
          if ((lock_dropped && locked) || wd_expired) begin
            state <= SEQ_IDLE;
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  // ******************************
  // read mux
  // ******************************

  // control reads as zero, unmapped addresses too
  always_comb begin
    rd_word = '0;
    case (req.addr)
      // bit 0 locked, bit 1 busy
      drp_pkg::ADDR_STATUS: rd_word = 32'({busy, locked});
      drp_pkg::ADDR_C0:     rd_word.cnt.cfg = shadow_c0;
      drp_pkg::ADDR_C1:     rd_word.cnt.cfg = shadow_c1;
      default:              rd_word = '0;
    endcase
  end

  assign rsp = '{busy: busy, rdata: rd_word};

endmodule

`default_nettype wire

// File: hw/serdes_clk_drp.sv
// processor side reconfiguration bridge
// latches one request, holds it against waitrequest,
// returns a ready pulse with registered read data,
// brings the generator lock flag into up_clk

`default_nettype none

module serdes_clk_drp #(
  parameter int ADDR_WIDTH = 12
) (

  // processor interface
  input  wire                       up_clk,
  input  wire                       up_rstn,
  input  wire                       up_drp_sel,
  input  wire                       up_drp_wr,
  input  wire [ADDR_WIDTH-1:0]      up_drp_addr,
  input  wire [31:0]                up_drp_wdata,
  output logic [31:0]               up_drp_rdata,
  output logic                      up_drp_ready,
  output logic                      up_drp_locked,

  // register file side
  output drp_pkg::drp_req_t         req,
  input  wire drp_pkg::drp_rsp_t    rsp,

  // lock flag from the generator, clk_in domain
  input  wire                       locked
);

  // first synchronizer stage
  logic locked_m;

  // a request is held while rd or wr is up
  logic req_held;
  logic req_done;

  assign req_held = req.rd | req.wr;

  // completes on the first edge with busy low
  assign req_done = req_held & ~rsp.busy;

  // ******************************
  // request hold and release
  // ******************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      req          <= '0;
      up_drp_ready <= 1'b0;
    end else begin
      // ready is a single cycle pulse
      up_drp_ready <= 1'b0;
      if (req_held) begin
        // sel is ignored while a request is outstanding
        if (req_done) begin
          req          <= '0;
          up_drp_ready <= 1'b1;
        end
      end else if (up_drp_sel) begin
        // wr low means read, upper address bits dropped
        req.rd    <= ~up_drp_wr;
        req.wr    <= up_drp_wr;
        req.addr  <= up_drp_addr[drp_pkg::DRP_AW-1:0];
        req.wdata <= up_drp_wdata;
      end
    end
  end

  // read data captured on completion, valid with ready
  always_ff @(posedge up_clk) begin
    if (req_done) begin
      up_drp_rdata <= rsp.rdata;
    end
  end

  // ******************************
  // lock synchronizer
  // ******************************

  // two flops, locked comes from the clk_in side
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      locked_m      <= 1'b0;
      up_drp_locked <= 1'b0;
    end else begin
      locked_m      <= locked;
      up_drp_locked <= locked_m;
    end
  end

endmodule

`default_nettype wire

// File: hw/drp_pkg.sv
// reconfiguration port definitions
// request and response structs between bridge and register file,
// register map and the write word union

`default_nettype none

package drp_pkg;

  // internal address width, the bridge keeps only these low bits
  localparam int DRP_AW = 9;

  // ******************************
  // register map
  // ******************************

  localparam logic [DRP_AW-1:0] ADDR_STATUS = 9'h000;
  localparam logic [DRP_AW-1:0] ADDR_CTRL   = 9'h001;
  localparam logic [DRP_AW-1:0] ADDR_C0     = 9'h002;
  localparam logic [DRP_AW-1:0] ADDR_C1     = 9'h003;

  // bridge to register file, rd or wr held until busy drops
  typedef struct packed {
    logic              rd;
    logic              wr;
    logic [DRP_AW-1:0] addr;
    logic [31:0]       wdata;
  } drp_req_t;

  // register file to bridge, busy is the waitrequest level
  typedef struct packed {
    logic        busy;
    logic [31:0] rdata;
  } drp_rsp_t;

  // ******************************
  // data word views
  // ******************************

  // counter registers c0 and c1
  typedef struct packed {
    logic [15:0]           rsvd;
    clk_cfg_pkg::cnt_cfg_t cfg;
  } drp_cnt_word_t;

  // control register, both bits self clearing
  typedef struct packed {
    logic [29:0] rsvd;
    logic        restart;
    logic        start;
  } drp_ctl_word_t;

  // one data word, decoded by address
  typedef union packed {
    drp_cnt_word_t cnt;
    drp_ctl_word_t ctl;
  } drp_word_t;

endpackage

`default_nettype wire

// File: hw/clk_cfg_pkg.sv
// clock generator configuration types
// output counter shape, active pll configuration,
// reset defaults and zero-as-one helpers

`default_nettype none

package clk_cfg_pkg;

  // ******************************
  // counter and configuration types
  // ******************************

  // one output counter, counted in clk_in cycles
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } cnt_cfg_t;

  // active configuration seen by the generator
  // c0 shapes div_clk, c1 sets the loaden period (hi + lo only)
  typedef struct packed {
    cnt_cfg_t c0;
    cnt_cfg_t c1;
  } pll_cfg_t;

  // ******************************
  // reset defaults
  // ******************************

  // div_clk 2/2, loaden every 8 cycles (serdes factor 8)
  localparam cnt_cfg_t C0_RESET = '{hi: 8'd2, lo: 8'd2};
  localparam cnt_cfg_t C1_RESET = '{hi: 8'd4, lo: 8'd4};
  localparam pll_cfg_t CFG_RESET = '{c0: C0_RESET, c1: C1_RESET};

  // a zero field counts as one cycle
  function automatic logic [7:0] cnt_eff(input logic [7:0] v);
    return (v == 8'd0) ? 8'd1 : v;
  endfunction

  // full counter period, hi plus lo, 9 bits so 255 + 255 fits
  function automatic logic [8:0] cnt_period(input cnt_cfg_t c);
    return {1'b0, cnt_eff(c.hi)} + {1'b0, cnt_eff(c.lo)};
  endfunction

endpackage

`default_nettype wire
